//--- all.f
logic/sdmac_pkg.sv
logic/dma_regs.sv
logic/scsi_fifo.sv
logic/cpu_sm_state.sv
logic/cpu_sm_outputs.sv
logic/sdmac_top.sv
verif/tb_sdmac.sv

//--- logic/cpu_sm_outputs.sv
// bus-master output decode
// turns the present state into host bus strobes and the fifo,
// address and count step pulses, grouped by output
`timescale 1ns/1ps

module cpu_sm_outputs (
    input  sdmac_pkg::cpu_state_e        state,
    input  sdmac_pkg::dma_cfg_t          cfg,
    input  logic [sdmac_pkg::word_w-1:0] head,
    output sdmac_pkg::bus_out_t          bus,
    output sdmac_pkg::sm_step_t          step
);

    // one term per state
    logic e_req;
    logic e_own;
    logic e_strobe;
    logic e_term;
    // engine owns the bus
    logic own_bus;

    assign e_req    = (state == sdmac_pkg::st_req);
    assign e_own    = (state == sdmac_pkg::st_own);
    assign e_strobe = (state == sdmac_pkg::st_strobe);
    assign e_term   = (state == sdmac_pkg::st_term);

    // breq
    assign bus.breq  = e_req;
    // bgack, held from own through term
    assign own_bus   = e_own | e_strobe | e_term;
    assign bus.bgack = own_bus;
    // as and ds, write cycle so both rise together
    assign bus.as    = e_strobe;
    assign bus.ds    = e_strobe;
    // rw, low while we write, read level otherwise
    assign bus.rw    = ~own_bus;
    // address and data only while bgack is driven
    assign bus.addr  = own_bus ? cfg.addr : '0;
    assign bus.data  = own_bus ? head : '0;

    // step pulses, one cycle at the end of the bus cycle
    assign step.pop       = e_term;
    assign step.inc_addr  = e_term;
    assign step.dec_count = e_term;

endmodule

//--- logic/cpu_sm_state.sv
// bus-master state machine, state register and next state
// one word per bus tenure: request, own, strobe until dsack, terminate
`timescale 1ns/1ps

module cpu_sm_state (
    input  logic                    clk,
    input  logic                    rst_n,
    input  sdmac_pkg::dma_cfg_t     cfg,
    input  logic                    empty,
    input  logic                    bg,
    input  logic                    dsack,
    output sdmac_pkg::cpu_state_e   state
);

    sdmac_pkg::cpu_state_e state_q;
    sdmac_pkg::cpu_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            sdmac_pkg::st_idle: begin
                // a word is waiting and the job is running
                if (cfg.active && !empty) begin
                    state_d = sdmac_pkg::st_req;
                end
            end
            sdmac_pkg::st_req: begin
                // host stopped the job before the grant, drop the request
                if (!cfg.active) begin
                    state_d = sdmac_pkg::st_idle;
                end else if (bg) begin
                    state_d = sdmac_pkg::st_own;
                end
            end
            sdmac_pkg::st_own: begin
                // address and data settle for one cycle before as
                state_d = sdmac_pkg::st_strobe;
            end
            sdmac_pkg::st_strobe: begin
                // memory ends the cycle, no limit on the wait
                if (dsack) begin
                    state_d = sdmac_pkg::st_term;
                end
            end
            sdmac_pkg::st_term: begin
                // step pulses fire here, bus is released
                // and requested again for the next word
                state_d = sdmac_pkg::st_idle;
            end
            default: begin
                state_d = sdmac_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= sdmac_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign state = state_q;

endmodule

//--- logic/dma_regs.sv
// dma host register block
// holds ctrl, addr, count and status, steps address and count on each
// finished bus cycle, flags done and overrun, returns registered reads
`timescale 1ns/1ps

module dma_regs (
    input  logic                               clk,
    input  logic                               rst_n,
    input  sdmac_pkg::host_req_t               host_req,
    output logic [sdmac_pkg::word_w-1:0]       rdata,
    output logic                               rvalid,
    input  sdmac_pkg::sm_step_t                step,
    input  logic                               ovr_pulse,
    input  logic [sdmac_pkg::fifo_aw:0]        level,
    output sdmac_pkg::dma_cfg_t                cfg
);

    logic                          go_q;
    logic                          done_q;
    logic                          ovr_q;
    logic [sdmac_pkg::word_w-1:0]  addr_q;
    logic [sdmac_pkg::count_w-1:0] count_q;

    // decoded host writes
    logic ctrl_wr;
    logic addr_wr;
    logic count_wr;
    // set when go is written as 1
    logic go_set;
    // this step moves the final word
    logic last_word;

    assign ctrl_wr   = host_req.wr && (host_req.sel == sdmac_pkg::reg_ctrl);
    assign addr_wr   = host_req.wr && (host_req.sel == sdmac_pkg::reg_addr);
    assign count_wr  = host_req.wr && (host_req.sel == sdmac_pkg::reg_count);
    assign go_set    = ctrl_wr && host_req.wdata[0];
    assign last_word = step.dec_count && (count_q == 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            go_q    <= 1'b0;
            done_q  <= 1'b0;
            ovr_q   <= 1'b0;
            addr_q  <= '0;
            count_q <= '0;
            rvalid  <= 1'b0;
        end else begin
            rvalid <= host_req.rd;
            // host write wins over the step pulses
            if (addr_wr) begin
                addr_q <= {host_req.wdata[sdmac_pkg::word_w-1:2], 2'b00};
            end else if (step.inc_addr) begin
                addr_q <= addr_q + sdmac_pkg::addr_step;
            end
            if (count_wr) begin
                count_q <= host_req.wdata[sdmac_pkg::count_w-1:0];
            end else if (step.dec_count) begin
                count_q <= count_q - 1'b1;
            end
            // go restarts the job and clears the sticky flags
            if (ctrl_wr) begin
                go_q <= host_req.wdata[0];
                if (go_set) begin
                    done_q <= 1'b0;
                end
            end else if (last_word) begin
                go_q   <= 1'b0;
                done_q <= 1'b1;
            end
            // a dropped scsi word beats a clear in the same cycle
            if (ovr_pulse) begin
                ovr_q <= 1'b1;
            end else if (go_set) begin
                ovr_q <= 1'b0;
            end
        end
    end

    // selected register captured on the rd strobe
    always_ff @(posedge clk) begin
        if (host_req.rd) begin
            case (host_req.sel)
                sdmac_pkg::reg_ctrl:   rdata <= {{(sdmac_pkg::word_w-1){1'b0}}, go_q};
                sdmac_pkg::reg_addr:   rdata <= addr_q;
                sdmac_pkg::reg_count:  rdata <= {{(sdmac_pkg::word_w-sdmac_pkg::count_w){1'b0}},
                                                 count_q};
                default:               rdata <= {{(sdmac_pkg::word_w-8){1'b0}},
                                                 level, 2'b00, ovr_q, done_q};
            endcase
        end
    end

    // bus master runs while go is set and words remain
    assign cfg.active = go_q && (count_q != '0);
    assign cfg.addr   = addr_q;

endmodule

//--- logic/scsi_fifo.sv
// scsi word fifo
// circular buffer filled by scsi strobes and drained by the bus master,
// a strobe into a full fifo is dropped and flagged with ovr_pulse
`timescale 1ns/1ps

module scsi_fifo (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr,
    input  logic [sdmac_pkg::word_w-1:0] wdata,
    input  logic                         pop,
    output logic [sdmac_pkg::word_w-1:0] head,
    output logic                         empty,
    output logic [sdmac_pkg::fifo_aw:0]  level,
    output logic                         ovr_pulse
);

    logic [sdmac_pkg::word_w-1:0]  mem [sdmac_pkg::fifo_depth];
    logic [sdmac_pkg::fifo_aw-1:0] wr_ptr;
    logic [sdmac_pkg::fifo_aw-1:0] rd_ptr;
    logic [sdmac_pkg::fifo_aw:0]   cnt;
    logic                          full;
    logic                          push;
    logic                          take;

    assign full  = (cnt == sdmac_pkg::fifo_depth);
    assign empty = (cnt == '0);
    // accepted write and accepted pop
    assign push  = wr && !full;
    assign take  = pop && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            // pointers wrap naturally at the power of two depth
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            if (push && !take) begin
                cnt <= cnt + 1'b1;
            end else if (take && !push) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    assign head      = mem[rd_ptr];
    assign level     = cnt;
    // word lost, tell the status register
    assign ovr_pulse = wr && full;

endmodule

//--- logic/sdmac_pkg.sv
// sdmac shared definitions
// widths, state and register encodings, and the structs that carry
// host accesses, dma configuration, step pulses and host bus outputs
package sdmac_pkg;

    // data and address word width
    localparam int word_w = 32;
    // fifo geometry, depth must stay a power of two
    localparam int fifo_depth = 8;
    localparam int fifo_aw = 3;
    // remaining word count register width
    localparam int count_w = 16;
    // byte step of the memory address per 32 bit word
    localparam logic [word_w-1:0] addr_step = 4;

    // bus-master cycle, one word per pass
    typedef enum logic [2:0] {
        st_idle,
        st_req,
        st_own,
        st_strobe,
        st_term
    } cpu_state_e;

    // host register map
    typedef enum logic [1:0] {
        reg_ctrl,
        reg_addr,
        reg_count,
        reg_status
    } reg_sel_e;

    // one host access, wr and rd are single cycle strobes
    typedef struct packed {
        logic              wr;
        logic              rd;
        reg_sel_e          sel;
        logic [word_w-1:0] wdata;
    } host_req_t;

    // registers to the bus master
    typedef struct packed {
        logic              active;
        logic [word_w-1:0] addr;
    } dma_cfg_t;

    // end of bus cycle pulses, all fire together
    typedef struct packed {
        logic pop;
        logic inc_addr;
        logic dec_count;
    } sm_step_t;

    // host bus outputs, active high strobes
    typedef struct packed {
        logic              breq;
        logic              bgack;
        logic              as;
        logic              ds;
        logic              rw;
        logic [word_w-1:0] addr;
        logic [word_w-1:0] data;
    } bus_out_t;

endpackage

//--- logic/sdmac_top.sv
// scsi to memory dma engine top level
// connects the host registers, scsi fifo, bus-master state machine
// and the output decode
`timescale 1ns/1ps

module sdmac_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  sdmac_pkg::host_req_t         host_req,
    output logic [sdmac_pkg::word_w-1:0] rdata,
    output logic                         rvalid,
    input  logic                         scsi_wr,
    input  logic [sdmac_pkg::word_w-1:0] scsi_data,
    input  logic                         bg,
    input  logic                         dsack,
    output sdmac_pkg::bus_out_t          bus
);

    sdmac_pkg::dma_cfg_t          cfg;
    sdmac_pkg::sm_step_t          step;
    sdmac_pkg::cpu_state_e        state;
    logic [sdmac_pkg::word_w-1:0] head;
    logic [sdmac_pkg::fifo_aw:0]  level;
    logic                         empty;
    logic                         ovr_pulse;

    dma_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .host_req  (host_req),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .step      (step),
        .ovr_pulse (ovr_pulse),
        .level     (level),
        .cfg       (cfg)
    );

    scsi_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (scsi_wr),
        .wdata     (scsi_data),
        .pop       (step.pop),
        .head      (head),
        .empty     (empty),
        .level     (level),
        .ovr_pulse (ovr_pulse)
    );

    cpu_sm_state u_state (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg),
        .empty (empty),
        .bg    (bg),
        .dsack (dsack),
        .state (state)
    );

    cpu_sm_outputs u_outputs (
        .state (state),
        .cfg   (cfg),
        .head  (head),
        .bus   (bus),
        .step  (step)
    );

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_sdmac -o sim_tb_sdmac &&
./obj_dir/sim_tb_sdmac || exit 1

//--- verif/tb_sdmac.sv
// testbench for the scsi to memory dma engine
// random scsi words and bus delays from an lcg, a memory responder for
// bg and dsack, and a fifo and address model checked at every bus write
`timescale 1ns/1ps

module tb_sdmac;

    localparam logic [31:0] seed = 32'h3f2b0d28;
    // 12 streamed, 3 leftovers drained, 8 after the overrun
    localparam int words_moved = 23;
    localparam int timeout_cycles = 200 * words_moved + 2000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    sdmac_pkg::host_req_t host_req;
    logic [31:0]          rdata;
    logic                 rvalid;
    logic                 scsi_wr;
    logic [31:0]          scsi_data;
    logic                 bg = 1'b0;
    logic                 dsack = 1'b0;
    sdmac_pkg::bus_out_t  bus;

    // separate random streams for the stimulus and the memory side
    logic [31:0] main_rnd = seed;
    logic [31:0] bus_rnd = seed;
    logic [31:0] exp_q[$];
    logic [31:0] exp_addr;
    logic [31:0] exp_count;
    logic [31:0] got;
    logic [31:0] base;
    int          mdl_level = 0;
    int          pend_pop = 0;
    int          captured = 0;
    int          dsack_seen = 0;
    int          as_falls = 0;
    int          cycles = 0;
    int          bg_wait = 0;
    int          ds_wait = 0;
    logic        bg_block = 1'b0;
    logic        quiet_check = 1'b0;
    logic        prev_bgack = 1'b0;
    logic        prev_breq = 1'b0;
    logic        prev_as = 1'b0;
    logic        prev_dsack = 1'b0;

    sdmac_top u_sdmac_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .host_req  (host_req),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .scsi_wr   (scsi_wr),
        .scsi_data (scsi_data),
        .bg        (bg),
        .dsack     (dsack),
        .bus       (bus)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        main_rnd = lcg(main_rnd);
        return main_rnd;
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s expected %08h actual %08h", name, exp, act);
            $display("Verification failed");
            $fatal(1, "run stopped at the first error");
        end
    endtask

    task automatic reg_write(input sdmac_pkg::reg_sel_e sel, input logic [31:0] data);
        @(negedge clk);
        host_req.wr    = 1'b1;
        host_req.sel   = sel;
        host_req.wdata = data;
        @(negedge clk);
        host_req.wr = 1'b0;
    endtask

    // read data and rvalid arrive one cycle after the rd strobe
    task automatic check_reg(input string name, input sdmac_pkg::reg_sel_e sel,
                             input logic [31:0] exp);
        @(negedge clk);
        host_req.rd  = 1'b1;
        host_req.sel = sel;
        @(negedge clk);
        host_req.rd = 1'b0;
        assert (rvalid) else stop_run("rvalid stayed low one cycle after a register read");
        check_value(name, exp, rdata);
    endtask

    task automatic scsi_send(input logic [31:0] data);
        @(negedge clk);
        scsi_wr   = 1'b1;
        scsi_data = data;
        @(negedge clk);
        scsi_wr = 1'b0;
    endtask

    // until n writes are captured and the engine has let go of the bus
    task automatic wait_bus_idle(input int n);
        wait (captured == n);
        @(negedge clk);
        while (bus.bgack) begin
            @(negedge clk);
        end
    endtask

    // memory responder, grant after a random delay, dsack pulse after as
    always @(negedge clk) begin
        if (rst_n) begin
            if (!bus.breq) begin
                bg      = 1'b0;
                bus_rnd = lcg(bus_rnd);
                bg_wait = int'(bus_rnd[17:16]);
            end else if (!bg_block) begin
                if (bg_wait == 0) bg = 1'b1;
                else bg_wait--;
            end
            if (dsack) begin
                dsack = 1'b0;
            end else if (bus.as) begin
                if (ds_wait == 0) dsack = 1'b1;
                else ds_wait--;
            end else begin
                bus_rnd = lcg(bus_rnd);
                ds_wait = int'(bus_rnd[18:16]) % 6;
            end
        end
    end

    // handshake rules, fifo model and write capture
    always @(posedge clk) begin
        int push_ok;
        if (rst_n) begin
            cycles++;
            if (cycles >= timeout_cycles) begin
                stop_run($sformatf("timeout after %0d cycles, transfer never finished", cycles));
            end
            assert (!bus.as || bus.bgack) else stop_run("as was high while bgack was low");
            assert (!(bus.bgack && !prev_bgack) || prev_breq)
                else stop_run("bgack rose without a breq before it");
            assert (!(prev_as && !bus.as) || prev_dsack)
                else stop_run("as fell without a dsack to end the write");
            assert (!quiet_check || !bus.breq) else stop_run("breq rose after the job ended");
            // a strobe into a full fifo is lost, a pop frees space only next edge
            push_ok = (scsi_wr && mdl_level < sdmac_pkg::fifo_depth) ? 1 : 0;
            if (push_ok == 1) exp_q.push_back(scsi_data);
            mdl_level = mdl_level + push_ok - pend_pop;
            pend_pop  = 0;
            if (dsack) dsack_seen++;
            if (prev_as && !bus.as) as_falls++;
            if (bus.as && dsack) begin
                assert (exp_q.size() > 0) else stop_run("bus write with no queued word");
                check_value("write data", exp_q.pop_front(), bus.data);
                check_value("write addr", exp_addr, bus.addr);
                check_value("write rw", 32'd0, {31'd0, bus.rw});
                check_value("write ds", 32'd1, {31'd0, bus.ds});
                exp_addr  = exp_addr + 32'd4;
                exp_count = exp_count - 32'd1;
                captured++;
                pend_pop = 1;
            end
            prev_bgack = bus.bgack;
            prev_breq  = bus.breq;
            prev_as    = bus.as;
            prev_dsack = dsack;
        end
    end

    initial begin
        rst_n     = 1'b0;
        host_req  = '0;
        scsi_wr   = 1'b0;
        scsi_data = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // register access and reset state
        check_value("reset strobes", 32'd0,
                    {27'd0, rvalid, bus.breq, bus.bgack, bus.as, bus.ds});
        check_reg("reset status", sdmac_pkg::reg_status, 32'd0);
        base = rand_word() & 32'h00ff_fffc;
        reg_write(sdmac_pkg::reg_addr, base);
        check_reg("addr readback", sdmac_pkg::reg_addr, base);
        got = rand_word() & 32'h0000_ffff;
        reg_write(sdmac_pkg::reg_count, got);
        check_reg("count readback", sdmac_pkg::reg_count, got);

        // twelve word transfer with random gaps
        base      = rand_word() & 32'h000f_fff0;
        exp_addr  = base;
        exp_count = 32'd12;
        reg_write(sdmac_pkg::reg_addr, base);
        reg_write(sdmac_pkg::reg_count, 32'd12);
        reg_write(sdmac_pkg::reg_ctrl, 32'd1);
        for (int i = 0; i < 12; i++) begin
            repeat (rand_word() % 8) @(negedge clk);
            while (mdl_level >= sdmac_pkg::fifo_depth - 1) @(negedge clk);
            scsi_send(rand_word());
        end
        wait_bus_idle(12);

        // completion, extra words stay put
        quiet_check = 1'b1;
        check_reg("done status", sdmac_pkg::reg_status, 32'h1);
        check_reg("final count", sdmac_pkg::reg_count, exp_count);
        repeat (3) scsi_send(rand_word());
        check_reg("leftover status", sdmac_pkg::reg_status, (mdl_level << 4) | 32'h1);
        repeat (20) @(negedge clk);
        quiet_check = 1'b0;

        // drain the leftovers before the overrun test
        exp_count = 32'd3;
        reg_write(sdmac_pkg::reg_count, 32'd3);
        reg_write(sdmac_pkg::reg_ctrl, 32'd1);
        wait_bus_idle(15);
        check_reg("drain status", sdmac_pkg::reg_status, 32'h1);

        // overrun with the grant held back
        bg_block  = 1'b1;
        base      = rand_word() & 32'h000f_fff0;
        exp_addr  = base;
        exp_count = 32'd8;
        reg_write(sdmac_pkg::reg_addr, base);
        reg_write(sdmac_pkg::reg_count, 32'd8);
        reg_write(sdmac_pkg::reg_ctrl, 32'd1);
        repeat (sdmac_pkg::fifo_depth + 3) scsi_send(rand_word());
        check_reg("overrun status", sdmac_pkg::reg_status, 32'h82);
        bg_block = 1'b0;
        wait_bus_idle(words_moved);
        check_reg("overrun done status", sdmac_pkg::reg_status, 32'h3);
        check_value("words left in model", 32'd0, exp_q.size());
        reg_write(sdmac_pkg::reg_ctrl, 32'd1);
        check_reg("cleared status", sdmac_pkg::reg_status, 32'h0);
        reg_write(sdmac_pkg::reg_ctrl, 32'd0);

        // every dsack pulse ends one strobe and no strobe ends without one
        check_value("dsack per write", dsack_seen, as_falls);
        $display("Verification passed");
        $finish;
    end

endmodule
